/* bench/main_bus_assertions.sv */
// **************************************************
// Bus handshake assertions
// **************************************************

module main_bus_assertions (
    input logic clk,
    input logic rst,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs
);

    int fail_count = 0;

    // Ack only answers a live request
    ack_in_request: assert property (@(posedge clk) disable iff (rst) ack |-> cyc && stb)
        else begin
            $error("ack seen outside cyc and stb");
            fail_count++;
        end

    ack_single_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else begin
            $error("ack held for two cycles");
            fail_count++;
        end

    // One external memory at a time
    cs_exclusive: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs}))
        else begin
            $error("more than one chip select active");
            fail_count++;
        end

endmodule

/* bench/main_bus_tb.sv */
// **************************************************
// Main bus testbench
// **************************************************

module main_bus_tb import main_bus_pkg::*; ();

    // About 130 accesses of at most ten cycles plus the interrupt frames, wide margin
    localparam int MAX_CYCLES = 20000;

    logic        clk = 1'b0;
    logic        rst;
    logic        cyc, stb, we;
    logic [1:0]  sel;
    addr_t       adr;
    data_t       dat_w, dat_r;
    logic        ack;
    logic        rom_cs;
    rom_addr_t   rom_addr;
    data_t       rom_data = '0;
    logic        rom_ok = 1'b0;
    logic        ram_cs, vram_cs, ram_we;
    logic [16:0] ram_addr;
    logic [1:0]  ram_sel;
    data_t       ram_wdata;
    data_t       ram_data = '0;
    logic        ram_ok = 1'b0;
    logic [1:0]  joymode;
    joy_t        joystick1, joystick2, joystick3, joystick4;
    logic [3:0]  start_button, coin_input;
    logic        service, dip_test, eeprom_sdo;
    logic [12:0] volume;
    logic        eeprom_scs, eeprom_sclk, eeprom_sdi, z80_rstn, obank;
    data_t       oram_base;
    logic        lvbl, raster, skip_en, int_ack, int_vblank_n, int_raster_n;

    // Memory models and their shadow copies
    int          rom_wait = 0;
    int          ram_wait = 0;
    rom_addr_t   rom_addr_seen = '0;
    logic [16:0] ram_addr_seen = '0;
    logic [1:0]  cs_seen = '0;
    data_t       wram_model [int];
    data_t       vram_model [int];
    data_t       wram_ref [int];
    data_t       vram_ref [int];

    logic  rd_pending = 1'b0;
    data_t exp_rd = '0;
    int    checks = 0;
    int    errors = 0;
    int    cycle_count = 0;

    main_bus dut0 (.*);

    bind region_decode main_bus_assertions u_assert (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle_count <= cycle_count + 1;

    function automatic data_t rom_word(input rom_addr_t x);
        return {x[20:16], 11'h2A5} ^ x[15:0];
    endfunction

    function automatic data_t fill_word(input int idx, input logic is_vram);
        return 16'(idx * 40503) ^ 16'(idx >>> 5) ^ (is_vram ? 16'hA5A5 : 16'h0000);
    endfunction

    // Work RAM keeps only its low 15 word address bits
    function automatic int ram_index(input addr_t a, input logic is_vram);
        return is_vram ? int'(a[16:0]) : int'(a[14:0]);
    endfunction

    function automatic data_t model_word(input int idx, input logic is_vram);
        if (is_vram)
            return vram_model.exists(idx) ? vram_model[idx] : fill_word(idx, 1'b1);
        return wram_model.exists(idx) ? wram_model[idx] : fill_word(idx, 1'b0);
    endfunction

    function automatic data_t ref_word(input int idx, input logic is_vram);
        if (is_vram)
            return vram_ref.exists(idx) ? vram_ref[idx] : fill_word(idx, 1'b1);
        return wram_ref.exists(idx) ? wram_ref[idx] : fill_word(idx, 1'b0);
    endfunction

    function automatic region_e target_of(input addr_t a, input logic w);
        logic [23:0] b;
        b = {a, 1'b0};
        if (b <= ROM_HI)
            return REGION_ROM;
        if (b == OBJCFG_ADDR)
            return w ? REGION_OBJCFG : REGION_NONE;
        if (b >= IO_LO && b <= IO_HI)
            return REGION_IO;
        if (b >= VRAM_LO && b <= VRAM_HI)
            return REGION_VRAM;
        if (b >= RAM_LO)
            return REGION_RAM;
        return REGION_NONE;
    endfunction

    // Cabinet word packing from the current stimulus
    function automatic data_t cab_word(input int idx);
        data_t w;
        if (idx == 0)
            w = {joystick2[7:0], joystick1[7:0]};
        else if (idx == 1)
            w = {joystick4[7:0], joystick3[7:0]};
        else
            w = {coin_input, start_button, 5'b11111, service, dip_test, eeprom_sdo};
        if (joymode == JOY_SIX_BUTTON) begin
            if (idx == 0) begin
                w[15] = 1'b1;
                w[7]  = 1'b1;
            end else if (idx == 1) begin
                w = {10'h3FF, joystick2[8:7], 1'b1, joystick1[9:7]};
            end else begin
                w[14] = joystick2[9];
            end
        end
        return w;
    endfunction

    function automatic data_t expected_read(input addr_t a);
        logic [23:0] b;
        data_t       w;
        b = {a, 1'b0};
        w = IDLE_DATA;
        case (target_of(a, 1'b0))
            REGION_ROM:  w = rom_word(a[20:0]);
            REGION_RAM:  w = ref_word(ram_index(a, 1'b0), 1'b0);
            REGION_VRAM: w = ref_word(ram_index(a, 1'b1), 1'b1);
            REGION_IO: begin
                if (b[8:3] == IO_IN0)
                    w = cab_word(0);
                else if (b[8:3] == IO_IN1)
                    w = cab_word(1);
                else if (b[8:3] == IO_IN2)
                    w = cab_word(2);
                else if (b[8:3] == IO_VOL)
                    w = {3'b111, volume};
            end
            default: w = IDLE_DATA;
        endcase
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at time %0t: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // ROM answers after 0 to 5 extra cycles
    always @(posedge clk) begin
        if (!rom_cs) begin
            rom_ok   <= 1'b0;
            rom_wait <= $urandom_range(5, 0);
        end else if (!rom_ok) begin
            if (rom_wait == 0) begin
                rom_ok        <= 1'b1;
                rom_data      <= rom_word(rom_addr);
                rom_addr_seen <= rom_addr;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    always @(posedge clk) begin : ram_model
        data_t w;
        if (!(ram_cs || vram_cs)) begin
            ram_ok   <= 1'b0;
            ram_wait <= $urandom_range(5, 0);
        end else if (!ram_ok) begin
            if (ram_wait == 0) begin
                ram_ok        <= 1'b1;
                cs_seen       <= {vram_cs, ram_cs};
                ram_addr_seen <= ram_addr;
                w = model_word(int'(ram_addr), vram_cs);
                if (ram_we) begin
                    if (ram_sel[1])
                        w[15:8] = ram_wdata[15:8];
                    if (ram_sel[0])
                        w[7:0] = ram_wdata[7:0];
                    if (vram_cs)
                        vram_model[int'(ram_addr)] = w;
                    else
                        wram_model[int'(ram_addr)] = w;
                end else begin
                    ram_data <= w;
                end
            end else begin
                ram_wait <= ram_wait - 1;
            end
        end
    end

    // Read data check on every ack of a read
    always @(posedge clk) begin
        if (ack && rd_pending)
            check_value("dat_r", 32'(exp_rd), 32'(dat_r));
    end

    task automatic bus_access(input bus_req_t r, output int ack_cycle);
        int n;
        @(posedge clk);
        exp_rd     <= expected_read(r.adr);
        rd_pending <= !r.we;
        cyc        <= 1'b1;
        stb        <= 1'b1;
        we         <= r.we;
        sel        <= r.sel;
        adr        <= r.adr;
        dat_w      <= r.dat;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!ack);
        // Cycle 0 is the one in which stb is first sampled
        ack_cycle = n - 1;
        cyc        <= 1'b0;
        stb        <= 1'b0;
        rd_pending <= 1'b0;
    endtask

    task automatic rom_read(input addr_t a);
        int c;
        bus_access('{adr: a, dat: '0, sel: 2'b11, we: 1'b0}, c);
        check_value("rom_addr", 32'(a[20:0]), 32'(rom_addr_seen));
    endtask

    task automatic ram_access(input addr_t a, input logic w, input logic [1:0] s,
                              input data_t d);
        int    c;
        int    idx;
        logic  is_vram;
        data_t old;
        is_vram = target_of(a, w) == REGION_VRAM;
        idx = ram_index(a, is_vram);
        bus_access('{adr: a, dat: d, sel: s, we: w}, c);
        check_value("ram_addr", 32'(idx), 32'(ram_addr_seen));
        check_value("vram_cs,ram_cs", 32'({is_vram, !is_vram}), 32'(cs_seen));
        if (w) begin
            old = ref_word(idx, is_vram);
            if (s[1])
                old[15:8] = d[15:8];
            if (s[0])
                old[7:0] = d[7:0];
            if (is_vram)
                vram_ref[idx] = old;
            else
                wram_ref[idx] = old;
        end
    endtask

    task automatic internal_access(input addr_t a, input logic w, input logic [1:0] s,
                                   input data_t d);
        int c;
        bus_access('{adr: a, dat: d, sel: s, we: w}, c);
        check_value("ack cycle", 32'd2, 32'(c));
    endtask

    task automatic io_access(input logic [5:0] off, input logic w, input logic [1:0] s,
                             input data_t d);
        internal_access(IO_LO[23:1] | {15'b0, off, 2'b00}, w, s, d);
    endtask

    task automatic pulse_int_ack();
        @(posedge clk);
        int_ack <= 1'b1;
        @(posedge clk);
        int_ack <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    initial begin
        wait (cycle_count >= MAX_CYCLES);
        $display("timeout: the bus stopped answering before the tests were done");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        addr_t a;
        addr_t written [$];
        logic  skip_ref;
        int    a_fails;
        void'($urandom(83941));
        rst = 1'b1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        sel = 2'b00;
        adr = '0;
        dat_w = '0;
        joymode = 2'd1;
        joystick1 = '1;
        joystick2 = '1;
        joystick3 = '1;
        joystick4 = '1;
        start_button = 4'hF;
        coin_input = 4'hF;
        service = 1'b1;
        dip_test = 1'b1;
        eeprom_sdo = 1'b0;
        volume = '0;
        lvbl = 1'b1;
        raster = 1'b0;
        skip_en = 1'b0;
        int_ack = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_value("ack", 32'd0, 32'(ack));
        check_value("rom_cs,ram_cs,vram_cs", 32'd0, 32'({rom_cs, ram_cs, vram_cs}));
        check_value("z80_rstn", 32'd0, 32'(z80_rstn));
        check_value("eeprom_scs,sclk,sdi", 32'd0,
                    32'({eeprom_scs, eeprom_sclk, eeprom_sdi}));
        check_value("obank", 32'd0, 32'(obank));
        check_value("int_vblank_n", 32'd1, 32'(int_vblank_n));
        check_value("int_raster_n", 32'd1, 32'(int_raster_n));
        check_value("oram_base", 32'd0, 32'(oram_base));

        // ROM, both ends of the range and random words
        rom_read(23'h000000);
        rom_read(23'h1FFFFF);
        for (int i = 0; i < 40; i++)
            rom_read(23'($urandom_range(32'h1FFFFF, 0)));

        // Work RAM and VRAM byte writes with read-back
        for (int i = 0; i < 24; i++) begin
            if (i % 2)
                a = 23'h480000 + 23'($urandom_range(32'h17FFF, 0));
            else
                a = 23'h7F8000 + 23'($urandom_range(32'h7FFF, 0));
            ram_access(a, 1'b1, 2'($urandom_range(3, 1)), 16'($urandom));
            ram_access(a, 1'b0, 2'b11, '0);
            written.push_back(a);
        end
        ram_access(23'h7F8010, 1'b1, 2'b11, 16'hBEEF);
        ram_access(23'h480010, 1'b0, 2'b11, '0);
        foreach (written[k])
            ram_access(written[k], 1'b0, 2'b11, '0);

        // Cabinet words in six-button mode and in a four-player mode
        for (int m = 0; m < 2; m++) begin
            @(posedge clk);
            joymode      <= (m == 0) ? JOY_SIX_BUTTON : 2'd2;
            joystick1    <= 10'($urandom);
            joystick2    <= 10'($urandom);
            joystick3    <= 10'($urandom);
            joystick4    <= 10'($urandom);
            start_button <= 4'($urandom);
            coin_input   <= 4'($urandom);
            service      <= 1'($urandom);
            dip_test     <= 1'($urandom);
            eeprom_sdo   <= 1'($urandom);
            volume       <= 13'($urandom);
            repeat (4) @(posedge clk);
            io_access(IO_IN0, 1'b0, 2'b11, '0);
            io_access(IO_IN1, 1'b0, 2'b11, '0);
            io_access(IO_IN2, 1'b0, 2'b11, '0);
            io_access(IO_VOL, 1'b0, 2'b11, '0);
        end
        @(posedge clk);
        start_button <= 4'hF;

        // System registers
        io_access(IO_OUT, 1'b1, 2'b10, 16'h5008);
        check_value("eeprom_scs,sclk,sdi", 32'b101,
                    32'({eeprom_scs, eeprom_sclk, eeprom_sdi}));
        check_value("z80_rstn", 32'd0, 32'(z80_rstn));
        io_access(IO_OUT, 1'b1, 2'b01, 16'h0008);
        check_value("z80_rstn", 32'd1, 32'(z80_rstn));
        check_value("eeprom_scs,sclk,sdi", 32'b101,
                    32'({eeprom_scs, eeprom_sclk, eeprom_sdi}));
        io_access(IO_OUT, 1'b1, 2'b11, 16'h2000);
        check_value("eeprom_scs,sclk,sdi", 32'b010,
                    32'({eeprom_scs, eeprom_sclk, eeprom_sdi}));
        check_value("z80_rstn", 32'd0, 32'(z80_rstn));
        io_access(IO_OBANK, 1'b1, 2'b01, 16'h0001);
        check_value("obank", 32'd1, 32'(obank));
        io_access(IO_OBANK, 1'b1, 2'b10, 16'h0000);
        check_value("obank", 32'd1, 32'(obank));
        internal_access(OBJCFG_ADDR[23:1], 1'b1, 2'b01, 16'h1234);
        check_value("oram_base", 32'h0034, 32'(oram_base));
        internal_access(OBJCFG_ADDR[23:1], 1'b1, 2'b10, 16'hAB00);
        check_value("oram_base", 32'hAB34, 32'(oram_base));

        // Unmapped reads, object config read and an unused I/O word
        internal_access(23'h280000, 1'b0, 2'b11, '0);
        internal_access(23'h500000, 1'b0, 2'b11, '0);
        internal_access(23'h200000, 1'b0, 2'b11, '0);
        internal_access(23'h400080, 1'b0, 2'b11, '0);
        internal_access(23'h498000, 1'b0, 2'b11, '0);
        internal_access(23'h7F0000, 1'b0, 2'b11, '0);

        // VBLANK and raster interrupts with acknowledge
        @(posedge clk);
        lvbl <= 1'b0;
        repeat (3) @(posedge clk);
        check_value("int_vblank_n", 32'd0, 32'(int_vblank_n));
        check_value("int_raster_n", 32'd1, 32'(int_raster_n));
        pulse_int_ack();
        check_value("int_vblank_n", 32'd1, 32'(int_vblank_n));
        raster <= 1'b1;
        repeat (3) @(posedge clk);
        check_value("int_raster_n", 32'd0, 32'(int_raster_n));
        pulse_int_ack();
        check_value("int_raster_n", 32'd1, 32'(int_raster_n));
        raster <= 1'b0;
        lvbl   <= 1'b1;
        repeat (3) @(posedge clk);

        // Frame skip, each VBLANK end flips skip while start is held
        skip_en      <= 1'b1;
        start_button <= 4'b1110;
        skip_ref = 1'b0;
        for (int f = 0; f < 4; f++) begin
            @(posedge clk);
            lvbl <= 1'b0;
            repeat (3) @(posedge clk);
            check_value("int_vblank_n", 32'(skip_ref), 32'(int_vblank_n));
            pulse_int_ack();
            lvbl <= 1'b1;
            repeat (3) @(posedge clk);
            skip_ref = !skip_ref;
        end
        skip_en      <= 1'b0;
        start_button <= 4'hF;
        repeat (2) @(posedge clk);

        a_fails = dut0.u_decode.u_assert.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, a_fails);
        if (errors == 0 && a_fails == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* flist.f */
verilog/main_bus_pkg.sv
verilog/region_decode.sv
verilog/cab_inputs.sv
verilog/sys_regs.sv
verilog/irq_gen.sv
verilog/main_bus.sv
bench/main_bus_assertions.sv
bench/main_bus_tb.sv

/* verilog/cab_inputs.sv */
// **************************************************
// Cabinet input words
// **************************************************

module cab_inputs import main_bus_pkg::*; (
    input  logic       clk,
    input  logic [1:0] joymode,
    input  joy_t       joystick1,
    input  joy_t       joystick2,
    input  joy_t       joystick3,
    input  joy_t       joystick4,
    input  logic [3:0] start_button,
    input  logic [3:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  logic       eeprom_sdo,
    output data_t      in0,
    output data_t      in1,
    output data_t      in2
);

    data_t base0;
    data_t base1;
    data_t base2;

    // Four players with up to eight lines each
    assign base0 = {joystick2[7:0], joystick1[7:0]};
    assign base1 = {joystick4[7:0], joystick3[7:0]};
    assign base2 = {coin_input, start_button, 5'b11111, service, dip_test, eeprom_sdo};

    always_ff @(posedge clk) begin
        in0 <= base0;
        in1 <= base1;
        in2 <= base2;
        if (joymode == JOY_SIX_BUTTON) begin
            // Only two players, extra buttons move to in1
            in0[15]  <= 1'b1;
            in0[7]   <= 1'b1;
            in1      <= 16'hFFFF;
            in1[2:0] <= joystick1[9:7];
            in1[5:4] <= joystick2[8:7];
            // Player 2 ninth button has no room left in in1
            in2[14]  <= joystick2[9];
        end
    end

endmodule

/* verilog/irq_gen.sv */
// **************************************************
// VBLANK and raster interrupts
// **************************************************

module irq_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       raster,
    input  logic       skip_en,
    input  logic [3:0] start_button,
    input  logic       int_ack,
    output logic       int_vblank_n,
    output logic       int_raster_n
);

    logic lvbl_l;
    logic raster_l;
    logic skip;
    logic vb_start;
    logic vb_end;
    logic raster_rise;

    assign vb_start    = !lvbl && lvbl_l;
    assign vb_end      = lvbl && !lvbl_l;
    assign raster_rise = raster && !raster_l;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l       <= 1'b0;
            raster_l     <= 1'b1;
            skip         <= 1'b0;
            int_vblank_n <= 1'b1;
            int_raster_n <= 1'b1;
        end else begin
            lvbl_l   <= lvbl;
            raster_l <= raster;
            // Start buttons are active low, any press toggles frame skip
            if (!skip_en)
                skip <= 1'b0;
            else if (vb_end)
                skip <= ~&start_button ? ~skip : 1'b0;
            if (int_ack) begin
                int_vblank_n <= 1'b1;
                int_raster_n <= 1'b1;
            end else begin
                if (vb_start && !skip)
                    int_vblank_n <= 1'b0;
                if (raster_rise && !skip)
                    int_raster_n <= 1'b0;
            end
        end
    end

endmodule

/* verilog/main_bus.sv */
// **************************************************
// CPS-2 main bus top
// **************************************************

module main_bus import main_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // Wishbone slave
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  sel,
    input  addr_t       adr,
    input  data_t       dat_w,
    output data_t       dat_r,
    output logic        ack,
    // ROM
    output logic        rom_cs,
    output rom_addr_t   rom_addr,
    input  data_t       rom_data,
    input  logic        rom_ok,
    // Work RAM and VRAM
    output logic        ram_cs,
    output logic        vram_cs,
    output logic [16:0] ram_addr,
    output logic        ram_we,
    output logic [1:0]  ram_sel,
    output data_t       ram_wdata,
    input  data_t       ram_data,
    input  logic        ram_ok,
    // Cabinet
    input  logic [1:0]  joymode,
    input  joy_t        joystick1,
    input  joy_t        joystick2,
    input  joy_t        joystick3,
    input  joy_t        joystick4,
    input  logic [3:0]  start_button,
    input  logic [3:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [12:0] volume,
    // EEPROM and system
    input  logic        eeprom_sdo,
    output logic        eeprom_scs,
    output logic        eeprom_sclk,
    output logic        eeprom_sdi,
    output logic        z80_rstn,
    output logic        obank,
    output data_t       oram_base,
    // Interrupts
    input  logic        lvbl,
    input  logic        raster,
    input  logic        skip_en,
    input  logic        int_ack,
    output logic        int_vblank_n,
    output logic        int_raster_n
);

    data_t  in0;
    data_t  in1;
    data_t  in2;
    io_wr_t io_wr;

    region_decode u_decode (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .sel(sel),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .ram_cs(ram_cs), .vram_cs(vram_cs), .ram_addr(ram_addr), .ram_we(ram_we),
        .ram_sel(ram_sel), .ram_wdata(ram_wdata), .ram_data(ram_data), .ram_ok(ram_ok),
        .in0(in0), .in1(in1), .in2(in2), .volume(volume), .io_wr(io_wr)
    );

    cab_inputs u_inputs (
        .clk(clk), .joymode(joymode),
        .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test), .eeprom_sdo(eeprom_sdo),
        .in0(in0), .in1(in1), .in2(in2)
    );

    sys_regs u_regs (
        .clk(clk), .rst(rst), .io_wr(io_wr),
        .eeprom_scs(eeprom_scs), .eeprom_sclk(eeprom_sclk), .eeprom_sdi(eeprom_sdi),
        .z80_rstn(z80_rstn), .obank(obank), .oram_base(oram_base)
    );

    irq_gen u_irq (
        .clk(clk), .rst(rst), .lvbl(lvbl), .raster(raster), .skip_en(skip_en),
        .start_button(start_button), .int_ack(int_ack),
        .int_vblank_n(int_vblank_n), .int_raster_n(int_raster_n)
    );

endmodule

/* verilog/main_bus_pkg.sv */
// **************************************************
// CPS-2 main bus shared definitions
// **************************************************

package main_bus_pkg;

    typedef logic [22:0] addr_t;
    typedef logic [15:0] data_t;
    typedef logic [20:0] rom_addr_t;
    typedef logic [9:0]  joy_t;

    // Request as latched from the Wishbone port
    typedef struct packed {
        addr_t      adr;
        data_t      dat;
        logic [1:0] sel;
        logic       we;
    } bus_req_t;

    // Write strobe into I/O or object-config space
    typedef struct packed {
        logic       valid;
        logic [5:0] offset;
        logic       cfg;
        logic [1:0] sel;
        data_t      data;
    } io_wr_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_ROM,
        REGION_RAM,
        REGION_VRAM,
        REGION_IO,
        REGION_OBJCFG
    } region_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_ACK
    } bus_state_e;

    // Byte address map
    localparam logic [23:0] ROM_LO      = 24'h000000;
    localparam logic [23:0] ROM_HI      = 24'h3FFFFF;
    localparam logic [23:0] OBJCFG_ADDR = 24'h400000;
    localparam logic [23:0] IO_LO       = 24'h800000;
    localparam logic [23:0] IO_HI       = 24'h87FFFF;
    localparam logic [23:0] VRAM_LO     = 24'h900000;
    localparam logic [23:0] VRAM_HI     = 24'h92FFFF;
    localparam logic [23:0] RAM_LO      = 24'hFF0000;

    // I/O word offsets, byte address bits 8 to 3
    localparam logic [5:0] IO_IN0   = 6'h00;
    localparam logic [5:0] IO_IN1   = 6'h02;
    localparam logic [5:0] IO_IN2   = 6'h04;
    localparam logic [5:0] IO_VOL   = 6'h06;
    localparam logic [5:0] IO_OUT   = 6'h08;
    localparam logic [5:0] IO_OBANK = 6'h1C;

    localparam logic [1:0] JOY_SIX_BUTTON = 2'd0;
    localparam data_t      IDLE_DATA      = 16'hFFFF;

endpackage

/* verilog/region_decode.sv */
// **************************************************
// Main bus region decoder
// **************************************************

module region_decode import main_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] sel,
    input  addr_t      adr,
    input  data_t      dat_w,
    output data_t      dat_r,
    output logic       ack,
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    input  data_t      rom_data,
    input  logic       rom_ok,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic [16:0] ram_addr,
    output logic       ram_we,
    output logic [1:0] ram_sel,
    output data_t      ram_wdata,
    input  data_t      ram_data,
    input  logic       ram_ok,
    input  data_t      in0,
    input  data_t      in1,
    input  data_t      in2,
    input  logic [12:0] volume,
    output io_wr_t     io_wr
);

    bus_state_e state;
    region_e    region;
    region_e    rgn_next;
    bus_req_t   req;
    logic [5:0] io_off;
    logic       wr_valid;
    logic       ext_busy;
    data_t      rd_word;

    function automatic region_e classify(input addr_t a, input logic w);
        logic [23:0] b;
        b = {a, 1'b0};
        if (b >= ROM_LO && b <= ROM_HI)
            return REGION_ROM;
        // Object config only answers writes
        else if (b == OBJCFG_ADDR && w)
            return REGION_OBJCFG;
        else if (b >= IO_LO && b <= IO_HI)
            return REGION_IO;
        else if (b >= VRAM_LO && b <= VRAM_HI)
            return REGION_VRAM;
        else if (b >= RAM_LO)
            return REGION_RAM;
        return REGION_NONE;
    endfunction

    assign rgn_next = classify(adr, we);
    assign io_off   = req.adr[7:2];
    assign ext_busy = (rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok);

    assign rom_addr  = req.adr[20:0];
    // Work RAM keeps to its own 64kB so it never aliases VRAM
    assign ram_addr  = (region == REGION_RAM) ? {2'b00, req.adr[14:0]} : req.adr[16:0];
    assign ram_we    = req.we;
    assign ram_sel   = req.sel;
    assign ram_wdata = req.dat;

    assign io_wr = '{valid: wr_valid, offset: io_off, cfg: region == REGION_OBJCFG,
                     sel: req.sel, data: req.dat};

    always_comb begin
        case (region)
            REGION_ROM:              rd_word = rom_data;
            REGION_RAM, REGION_VRAM: rd_word = ram_data;
            REGION_IO: begin
                case (io_off)
                    IO_IN0:  rd_word = in0;
                    IO_IN1:  rd_word = in1;
                    IO_IN2:  rd_word = in2;
                    IO_VOL:  rd_word = {3'b111, volume};
                    default: rd_word = IDLE_DATA;
                endcase
            end
            default:                 rd_word = IDLE_DATA;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            region   <= REGION_NONE;
            ack      <= 1'b0;
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            wr_valid <= 1'b0;
        end else begin
            ack      <= 1'b0;
            wr_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cyc && stb) begin
                        region   <= rgn_next;
                        rom_cs   <= rgn_next == REGION_ROM;
                        ram_cs   <= rgn_next == REGION_RAM;
                        vram_cs  <= rgn_next == REGION_VRAM;
                        wr_valid <= we && (rgn_next == REGION_IO || rgn_next == REGION_OBJCFG);
                        state    <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Internal targets never stall
                    if (!ext_busy) begin
                        ack     <= 1'b1;
                        rom_cs  <= 1'b0;
                        ram_cs  <= 1'b0;
                        vram_cs <= 1'b0;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK:  state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cyc && stb)
            req <= '{adr: adr, dat: dat_w, sel: sel, we: we};
        if (state == ST_WAIT && !ext_busy)
            dat_r <= rd_word;
    end

endmodule

/* verilog/sys_regs.sv */
// **************************************************
// System write registers
// **************************************************

module sys_regs import main_bus_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  io_wr_t io_wr,
    output logic   eeprom_scs,
    output logic   eeprom_sclk,
    output logic   eeprom_sdi,
    output logic   z80_rstn,
    output logic   obank,
    output data_t  oram_base
);

    logic out_hi_wr;
    logic out_lo_wr;
    logic obank_wr;
    logic cfg_wr;

    // Byte lane strobes per register
    assign out_hi_wr = io_wr.valid && !io_wr.cfg && io_wr.offset == IO_OUT && io_wr.sel[1];
    assign out_lo_wr = io_wr.valid && !io_wr.cfg && io_wr.offset == IO_OUT && io_wr.sel[0];
    assign obank_wr  = io_wr.valid && !io_wr.cfg && io_wr.offset == IO_OBANK && io_wr.sel[0];
    assign cfg_wr    = io_wr.valid && io_wr.cfg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            eeprom_scs  <= 1'b0;
            eeprom_sclk <= 1'b0;
            eeprom_sdi  <= 1'b0;
            z80_rstn    <= 1'b0;
            obank       <= 1'b0;
            oram_base   <= '0;
        end else begin
            // EEPROM is bit-banged through the high byte
            if (out_hi_wr) begin
                eeprom_scs  <= io_wr.data[14];
                eeprom_sclk <= io_wr.data[13];
                eeprom_sdi  <= io_wr.data[12];
            end
            // Sound CPU held in reset until software releases it
            if (out_lo_wr)
                z80_rstn <= io_wr.data[3];
            if (obank_wr)
                obank <= io_wr.data[0];
            if (cfg_wr) begin
                if (io_wr.sel[1])
                    oram_base[15:8] <= io_wr.data[15:8];
                if (io_wr.sel[0])
                    oram_base[7:0] <= io_wr.data[7:0];
            end
        end
    end

endmodule
